//--- logic/paCorePkg.sv
package paCorePkg;

	//////////////////////////////
	// datapath geometry
	//////////////////////////////
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 5;
	localparam int regCount = 1 << regAddrWidth;
	localparam int pcWidth = 16;
	localparam int shiftByteWidth = 8;

	// icache line and bundle layout
	localparam int lineBytes = 32;
	localparam int lineWidth = lineBytes * shiftByteWidth;
	localparam int lineOffsetWidth = $clog2(lineBytes);
	localparam int cacheLines = 8;
	localparam int lineAddrWidth = $clog2(cacheLines);
	localparam int bundleBytes = 8;
	localparam int bundleWidth = bundleBytes * shiftByteWidth;
	localparam int bundleOffsetWidth = $clog2(bundleBytes);
	localparam int bundlesPerLine = lineBytes / bundleBytes;
	localparam int bundleIdxWidth = $clog2(bundlesPerLine);
	localparam int instrWidth = 32;

	//////////////////////////////
	// instruction fields
	//////////////////////////////
	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 25;
	localparam int opcodeWidth = opcodeMsb - opcodeLsb + 1;
	// set when the secondary field is an immediate
	localparam int formatBit = 24;
	localparam int primRegMsb = 23;
	localparam int primRegLsb = 19;
	localparam int secFieldMsb = 15;
	localparam int secFieldLsb = 0;

	// anything past OP_MOV decodes as a nop
	typedef enum logic [opcodeWidth-1:0] {
		OP_NOP = 7'd0,
		OP_ADD = 7'd1,
		OP_SUB = 7'd2,
		OP_AND = 7'd3,
		OP_OR = 7'd4,
		OP_XOR = 7'd5,
		OP_MOV = 7'd6
	} opcodeT;

endpackage

//--- logic/laneOpIf.sv
`timescale 1ns/10ps

// one decoded lane op, decoder to register file
interface laneOpIf import paCorePkg::*; ();
	logic valid;
	opcodeT opcode;
	// primary is both source and destination
	logic [regAddrWidth-1:0] primReg;
	logic readPrim;
	// secondary field is a register number when set
	logic secIsReg;
	logic [dataWidth-1:0] secField;
	logic writeEnable;

	modport decoderPort (
		output valid, opcode, primReg, readPrim, secIsReg, secField, writeEnable
	);

	modport regFilePort (
		input valid, opcode, primReg, readPrim, secIsReg, secField, writeEnable
	);

endinterface

//--- logic/issueIf.sv
`timescale 1ns/10ps

// operand-ready op, register file to alu
interface issueIf import paCorePkg::*; ();
	logic valid;
	opcodeT opcode;
	logic [regAddrWidth-1:0] destReg;
	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;

	modport regFilePort (
		output valid, opcode, destReg, operandA, operandB
	);

	modport aluPort (
		input valid, opcode, destReg, operandA, operandB
	);

endinterface

//--- logic/cacheLoadShifter.sv
`timescale 1ns/10ps

module cacheLoadShifter import paCorePkg::*;
(
	input logic clock_i,
	input logic reset_i,
	input logic shiftEn_i,
	input logic isAddress_i,
	input logic shiftOutEn_i,
	input logic [shiftByteWidth-1:0] shiftData_i,
	output logic cacheWrite_o,
	output logic [lineAddrWidth-1:0] lineAddr_o,
	output logic [lineWidth-1:0] lineData_o
);

	// byte carries data or address, not a write request
	logic takeByte;

	assign takeByte = shiftEn_i && !shiftOutEn_i;

	//////////////////////////////
	// control
	//////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			cacheWrite_o <= 1'b0;
			lineAddr_o <= '0;
		end
		else
		begin
			// write lands one cycle after the request
			cacheWrite_o <= shiftEn_i && shiftOutEn_i;
			// only the low bits address a line
			if (takeByte && isAddress_i)
				lineAddr_o <= shiftData_i[lineAddrWidth-1:0];
		end
	end

	// newest byte in at the top, so the first byte ends at byte 0
	always_ff @(posedge clock_i)
	begin
		if (takeByte && !isAddress_i)
			lineData_o <= {shiftData_i, lineData_o[lineWidth-1:shiftByteWidth]};
	end

endmodule

//--- logic/instructionCache.sv
`timescale 1ns/10ps

module instructionCache import paCorePkg::*;
(
	input logic clock_i,
	input logic write_i,
	input logic [lineAddrWidth-1:0] writeAddr_i,
	input logic [lineWidth-1:0] writeLine_i,
	input logic fetchValid_i,
	input logic [pcWidth-1:0] pc_i,
	output logic [lineWidth-1:0] line_o,
	output logic lineValid_o,
	output logic [bundleIdxWidth-1:0] bundleIdx_o
);

	logic [lineWidth-1:0] mem [cacheLines];
	// line field of the pc
	logic [lineAddrWidth-1:0] fetchLine;

	assign fetchLine = pc_i[lineOffsetWidth +: lineAddrWidth];

	// loader write port
	always_ff @(posedge clock_i)
	begin
		if (write_i)
			mem[writeAddr_i] <= writeLine_i;
	end

	// registered fetch, bundle index and valid ride along
	always_ff @(posedge clock_i)
	begin
		// a line written this cycle is passed straight through
		if (write_i && writeAddr_i == fetchLine)
			line_o <= writeLine_i;
		else
			line_o <= mem[fetchLine];
		lineValid_o <= fetchValid_i;
		bundleIdx_o <= pc_i[bundleOffsetWidth +: bundleIdxWidth];
	end

endmodule

//--- logic/bundleSplitter.sv
`timescale 1ns/10ps

module bundleSplitter import paCorePkg::*;
(
	input logic clock_i,
	input logic reset_i,
	input logic [lineWidth-1:0] line_i,
	input logic lineValid_i,
	input logic [bundleIdxWidth-1:0] bundleIdx_i,
	output logic [instrWidth-1:0] instrA_o,
	output logic [instrWidth-1:0] instrB_o,
	output logic valid_o
);

	logic [bundleWidth-1:0] bundle;

	// bundle slot within the line
	assign bundle = line_i[bundleIdx_i * bundleWidth +: bundleWidth];

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			valid_o <= 1'b0;
		else
			valid_o <= lineValid_i;
	end

	// lane a low word, lane b high word
	always_ff @(posedge clock_i)
	begin
		instrA_o <= bundle[instrWidth-1:0];
		instrB_o <= bundle[2*instrWidth-1:instrWidth];
	end

endmodule

//--- logic/instructionDecoder.sv
`timescale 1ns/10ps

module instructionDecoder import paCorePkg::*;
(
	input logic clock_i,
	input logic reset_i,
	input logic [instrWidth-1:0] instr_i,
	input logic valid_i,
	laneOpIf.decoderPort laneOp
);

	logic [opcodeWidth-1:0] rawOp;
	opcodeT opcode;
	logic knownOp;

	assign rawOp = instr_i[opcodeMsb:opcodeLsb];

	// out of range opcodes fold onto nop
	always_comb
	begin
		if (rawOp <= OP_MOV)
			opcode = opcodeT'(rawOp);
		else
			opcode = OP_NOP;
	end

	// every known op writes its primary register
	assign knownOp = opcode != OP_NOP;

	//////////////////////////////
	// decode register
	//////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			laneOp.valid <= 1'b0;
		else
			laneOp.valid <= valid_i;
	end

	always_ff @(posedge clock_i)
	begin
		laneOp.opcode <= opcode;
		laneOp.primReg <= instr_i[primRegMsb:primRegLsb];
		laneOp.secField <= instr_i[secFieldMsb:secFieldLsb];
		laneOp.writeEnable <= knownOp;
		// mov ignores its primary source
		laneOp.readPrim <= knownOp && opcode != OP_MOV;
		laneOp.secIsReg <= !instr_i[formatBit];
	end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/10ps

module registerFile import paCorePkg::*;
(
	input logic clock_i,
	input logic reset_i,
	laneOpIf.regFilePort laneOpA,
	laneOpIf.regFilePort laneOpB,
	issueIf.regFilePort issueA,
	issueIf.regFilePort issueB,
	input logic wbEnableA_i,
	input logic [regAddrWidth-1:0] wbAddrA_i,
	input logic [dataWidth-1:0] wbDataA_i,
	input logic wbEnableB_i,
	input logic [regAddrWidth-1:0] wbAddrB_i,
	input logic [dataWidth-1:0] wbDataB_i
);

	logic [dataWidth-1:0] regs [regCount];
	logic [regAddrWidth-1:0] secRegA, secRegB;
	logic [dataWidth-1:0] primReadA, secReadA, primReadB, secReadB;
	// issue stage, operands held as read
	logic issueValidA, issueValidB;
	opcodeT heldOpA, heldOpB;
	logic [regAddrWidth-1:0] heldDestA, heldDestB, heldSecRegA, heldSecRegB;
	logic [dataWidth-1:0] heldPrimA, heldSecA, heldPrimB, heldSecB;
	logic lateFwdPrimA, lateFwdSecA, lateFwdPrimB, lateFwdSecB;

	// current writeback wins over the stored value, lane b checked last
	function automatic logic [dataWidth-1:0] forwardValue(
		input logic [regAddrWidth-1:0] addr,
		input logic [dataWidth-1:0] stored
	);
		logic [dataWidth-1:0] value;
		value = stored;
		if (wbEnableA_i && wbAddrA_i == addr)
			value = wbDataA_i;
		if (wbEnableB_i && wbAddrB_i == addr)
			value = wbDataB_i;
		return value;
	endfunction

	//////////////////////////////
	// write ports, b after a
	//////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (wbEnableA_i)
				regs[wbAddrA_i] <= wbDataA_i;
			if (wbEnableB_i)
				regs[wbAddrB_i] <= wbDataB_i;
		end
	end

	//////////////////////////////
	// operand read
	//////////////////////////////
	assign secRegA = laneOpA.secField[regAddrWidth-1:0];
	assign secRegB = laneOpB.secField[regAddrWidth-1:0];

	// writeback seen here is two bundles back
	always_comb
	begin
		primReadA = laneOpA.readPrim ? forwardValue(laneOpA.primReg, regs[laneOpA.primReg]) : '0;
		primReadB = laneOpB.readPrim ? forwardValue(laneOpB.primReg, regs[laneOpB.primReg]) : '0;
		secReadA = laneOpA.secIsReg ? forwardValue(secRegA, regs[secRegA]) : laneOpA.secField;
		secReadB = laneOpB.secIsReg ? forwardValue(secRegB, regs[secRegB]) : laneOpB.secField;
	end

	// nops never issue
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			issueValidA <= 1'b0;
			issueValidB <= 1'b0;
		end
		else
		begin
			issueValidA <= laneOpA.valid && laneOpA.writeEnable;
			issueValidB <= laneOpB.valid && laneOpB.writeEnable;
		end
	end

	always_ff @(posedge clock_i)
	begin
		heldOpA <= laneOpA.opcode;
		heldDestA <= laneOpA.primReg;
		heldPrimA <= primReadA;
		heldSecA <= secReadA;
		heldSecRegA <= secRegA;
		lateFwdPrimA <= laneOpA.readPrim;
		lateFwdSecA <= laneOpA.secIsReg;
		heldOpB <= laneOpB.opcode;
		heldDestB <= laneOpB.primReg;
		heldPrimB <= primReadB;
		heldSecB <= secReadB;
		heldSecRegB <= secRegB;
		lateFwdPrimB <= laneOpB.readPrim;
		lateFwdSecB <= laneOpB.secIsReg;
	end

	//////////////////////////////
	// issue outputs
	//////////////////////////////
	assign issueA.valid = issueValidA;
	assign issueA.opcode = heldOpA;
	assign issueA.destReg = heldDestA;
	assign issueB.valid = issueValidB;
	assign issueB.opcode = heldOpB;
	assign issueB.destReg = heldDestB;

	// late forward covers the bundle just ahead, whose result is on wb now
	always_comb
	begin
		issueA.operandA = lateFwdPrimA ? forwardValue(heldDestA, heldPrimA) : heldPrimA;
		issueA.operandB = lateFwdSecA ? forwardValue(heldSecRegA, heldSecA) : heldSecA;
		issueB.operandA = lateFwdPrimB ? forwardValue(heldDestB, heldPrimB) : heldPrimB;
		issueB.operandB = lateFwdSecB ? forwardValue(heldSecRegB, heldSecB) : heldSecB;
	end

endmodule

//--- logic/arithmeticUnit.sv
`timescale 1ns/10ps

module arithmeticUnit import paCorePkg::*;
(
	input logic clock_i,
	input logic reset_i,
	issueIf.aluPort issue,
	output logic wbEnable_o,
	output logic [regAddrWidth-1:0] wbAddr_o,
	output logic [dataWidth-1:0] wbData_o
);

	logic [dataWidth-1:0] result;

	// all results wrap at 16 bits
	always_comb
	begin
		case (issue.opcode)
			OP_ADD: result = issue.operandA + issue.operandB;
			OP_SUB: result = issue.operandA - issue.operandB;
			OP_AND: result = issue.operandA & issue.operandB;
			OP_OR: result = issue.operandA | issue.operandB;
			OP_XOR: result = issue.operandA ^ issue.operandB;
			OP_MOV: result = issue.operandB;
			default: result = '0;
		endcase
	end

	// writeback register
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			wbEnable_o <= 1'b0;
		else
			wbEnable_o <= issue.valid;
	end

	always_ff @(posedge clock_i)
	begin
		wbAddr_o <= issue.destReg;
		wbData_o <= result;
	end

endmodule

//--- logic/paCore.sv
`timescale 1ns/10ps

module paCore import paCorePkg::*;
(
	input logic clock_i,
	input logic reset_i,
	input logic shiftEn_i,
	input logic isAddress_i,
	input logic shiftOutEn_i,
	input logic [shiftByteWidth-1:0] shiftData_i,
	output logic [pcWidth-1:0] pc_o,
	output logic wbEnableA_o,
	output logic wbEnableB_o,
	output logic [regAddrWidth-1:0] wbAddrA_o,
	output logic [regAddrWidth-1:0] wbAddrB_o,
	output logic [dataWidth-1:0] wbDataA_o,
	output logic [dataWidth-1:0] wbDataB_o
);

	logic fetchValid;
	// loader to cache
	logic cacheWrite;
	logic [lineAddrWidth-1:0] lineAddr;
	logic [lineWidth-1:0] lineData;
	// cache to splitter
	logic [lineWidth-1:0] fetchedLine;
	logic lineValid;
	logic [bundleIdxWidth-1:0] bundleIdx;
	// splitter to decoders
	logic [instrWidth-1:0] instrA, instrB;
	logic instrValid;

	laneOpIf laneOpA ();
	laneOpIf laneOpB ();
	issueIf issueA ();
	issueIf issueB ();

	//////////////////////////////
	// program counter
	//////////////////////////////
	// held while the loader owns the cache
	assign fetchValid = !reset_i && !shiftEn_i;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			pc_o <= '0;
		else if (!shiftEn_i)
			pc_o <= pc_o + pcWidth'(bundleBytes);
	end

	cacheLoadShifter u_loader (.clock_i(clock_i), .reset_i(reset_i), .shiftEn_i(shiftEn_i),
		.isAddress_i(isAddress_i), .shiftOutEn_i(shiftOutEn_i), .shiftData_i(shiftData_i),
		.cacheWrite_o(cacheWrite), .lineAddr_o(lineAddr), .lineData_o(lineData));

	instructionCache u_icache (.clock_i(clock_i), .write_i(cacheWrite), .writeAddr_i(lineAddr),
		.writeLine_i(lineData), .fetchValid_i(fetchValid), .pc_i(pc_o), .line_o(fetchedLine),
		.lineValid_o(lineValid), .bundleIdx_o(bundleIdx));

	bundleSplitter u_splitter (.clock_i(clock_i), .reset_i(reset_i), .line_i(fetchedLine),
		.lineValid_i(lineValid), .bundleIdx_i(bundleIdx), .instrA_o(instrA), .instrB_o(instrB),
		.valid_o(instrValid));

	//////////////////////////////
	// lanes
	//////////////////////////////
	instructionDecoder u_decodeA (.clock_i(clock_i), .reset_i(reset_i), .instr_i(instrA),
		.valid_i(instrValid), .laneOp(laneOpA));

	instructionDecoder u_decodeB (.clock_i(clock_i), .reset_i(reset_i), .instr_i(instrB),
		.valid_i(instrValid), .laneOp(laneOpB));

	// writebacks feed the file and leave the core
	registerFile u_regFile (.clock_i(clock_i), .reset_i(reset_i), .laneOpA(laneOpA),
		.laneOpB(laneOpB), .issueA(issueA), .issueB(issueB),
		.wbEnableA_i(wbEnableA_o), .wbAddrA_i(wbAddrA_o), .wbDataA_i(wbDataA_o),
		.wbEnableB_i(wbEnableB_o), .wbAddrB_i(wbAddrB_o), .wbDataB_i(wbDataB_o));

	arithmeticUnit u_aluA (.clock_i(clock_i), .reset_i(reset_i), .issue(issueA),
		.wbEnable_o(wbEnableA_o), .wbAddr_o(wbAddrA_o), .wbData_o(wbDataA_o));

	arithmeticUnit u_aluB (.clock_i(clock_i), .reset_i(reset_i), .issue(issueB),
		.wbEnable_o(wbEnableB_o), .wbAddr_o(wbAddrB_o), .wbData_o(wbDataB_o));

endmodule

//--- verif/paCoreTb.sv
`timescale 1ns/10ps

module paCoreTb import paCorePkg::*; ();

	localparam int clockPeriod = 100;
	localparam int resetCycles = 5;
	// cache read, splitter, decoder, issue, alu
	localparam int pipeDepth = 5;
	localparam int programBundles = cacheLines * bundlesPerLine;
	// address byte, 32 data bytes and the write request per line
	localparam int loadCycles = cacheLines * (lineBytes + 2);
	localparam int cycleLimit = loadCycles + programBundles + pipeDepth + 20;
	localparam int recordWidth = regAddrWidth + dataWidth;

	logic clock_i = 1'b0;
	logic reset_i;
	logic shiftEn_i;
	logic isAddress_i;
	logic shiftOutEn_i;
	logic [shiftByteWidth-1:0] shiftData_i;
	logic [pcWidth-1:0] pc_o;
	logic wbEnableA_o;
	logic wbEnableB_o;
	logic [regAddrWidth-1:0] wbAddrA_o;
	logic [regAddrWidth-1:0] wbAddrB_o;
	logic [dataWidth-1:0] wbDataA_o;
	logic [dataWidth-1:0] wbDataB_o;

	// program image from the data file
	logic [lineWidth-1:0] lineImage [cacheLines];
	logic [shiftByteWidth-1:0] lineTarget [cacheLines];
	int lineCount = 0;
	// expected writebacks with the register on top of the value
	logic [recordWidth-1:0] expectedA [$];
	logic [recordWidth-1:0] expectedB [$];

	logic running = 1'b0;
	int runCycle = 0;
	int checkCount = 0;
	int errorCount = 0;
	int cycleCount;

	paCore u_dut (.clock_i(clock_i), .reset_i(reset_i), .shiftEn_i(shiftEn_i),
		.isAddress_i(isAddress_i), .shiftOutEn_i(shiftOutEn_i), .shiftData_i(shiftData_i),
		.pc_o(pc_o), .wbEnableA_o(wbEnableA_o), .wbEnableB_o(wbEnableB_o),
		.wbAddrA_o(wbAddrA_o), .wbAddrB_o(wbAddrB_o), .wbDataA_o(wbDataA_o),
		.wbDataB_o(wbDataB_o));

	always #(clockPeriod / 2) clock_i = ~clock_i;

	//////////////////////////////
	// checking helpers
	//////////////////////////////
	task automatic expectEqual(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else
		begin
			errorCount++;
			$display("FAIL at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	// pops the next record of a lane when it writes
	task automatic checkWriteback(input int lane, input logic enable,
		input logic [regAddrWidth-1:0] addr, input logic [dataWidth-1:0] data);
		logic [recordWidth-1:0] record;
		logic haveRecord;
		string laneName;
		laneName = (lane == 0) ? "A" : "B";
		if (!enable)
			return;
		haveRecord = (lane == 0) ? (expectedA.size() > 0) : (expectedB.size() > 0);
		assert (haveRecord) else
		begin
			errorCount++;
			$display("ERROR at %0t: lane %s wrote r%0d with no expected writeback left",
				$time, laneName, addr);
		end
		if (!haveRecord)
			return;
		if (lane == 0)
			record = expectedA.pop_front();
		else
			record = expectedB.pop_front();
		expectEqual({"wbAddr", laneName, "_o"}, 32'(record[recordWidth-1 -: regAddrWidth]),
			32'(addr));
		expectEqual({"wbData", laneName, "_o"}, 32'(record[dataWidth-1:0]), 32'(data));
	endtask

	// check at the falling edge, then step to just past the rising edge
	task automatic stepCycle();
		logic [pcWidth-1:0] expectedPc;
		@(negedge clock_i);
		if (!running)
		begin
			// pc parked and nothing retires in reset or loading
			expectEqual("pc_o", 32'h0, 32'(pc_o));
			expectEqual("wbEnableA_o", 32'h0, 32'(wbEnableA_o));
			expectEqual("wbEnableB_o", 32'h0, 32'(wbEnableB_o));
		end
		else
		begin
			expectedPc = pcWidth'(runCycle * bundleBytes);
			expectEqual("pc_o", 32'(expectedPc), 32'(pc_o));
			if (runCycle < pipeDepth)
			begin
				// only drained slots so far
				expectEqual("wbEnableA_o", 32'h0, 32'(wbEnableA_o));
				expectEqual("wbEnableB_o", 32'h0, 32'(wbEnableB_o));
			end
			else
			begin
				// bundle 0 writes in both lanes
				if (runCycle == pipeDepth)
				begin
					expectEqual("wbEnableA_o", 32'h1, 32'(wbEnableA_o));
					expectEqual("wbEnableB_o", 32'h1, 32'(wbEnableB_o));
				end
				checkWriteback(0, wbEnableA_o, wbAddrA_o, wbDataA_o);
				checkWriteback(1, wbEnableB_o, wbAddrB_o, wbDataB_o);
			end
		end
		@(posedge clock_i);
		#1;
	endtask

	//////////////////////////////
	// program file and loader
	//////////////////////////////
	task automatic readProgram();
		int fd;
		int code;
		logic [7:0] tag;
		logic knownTag;
		logic [31:0] addr;
		logic [31:0] regNum;
		logic [31:0] value;
		logic [31:0] words [2*bundlesPerLine];
		logic [lineWidth-1:0] bits;
		logic [8*120-1:0] rest;
		fd = $fopen("verif/program_input.txt", "r");
		assert (fd != 0) else
		begin
			errorCount++;
			$display("ERROR: cannot open verif/program_input.txt");
		end
		if (fd == 0)
			return;
		while ($fscanf(fd, " %c", tag) == 1)
		begin
			knownTag = (tag == "#" || tag == "L" || tag == "A" || tag == "B");
			assert (knownTag) else
			begin
				errorCount++;
				$display("ERROR: unknown record type in the program file");
			end
			if (tag == "#")
				code = $fgets(rest, fd);
			else if (tag == "L")
			begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", addr, words[0], words[1],
					words[2], words[3], words[4], words[5], words[6], words[7]);
				// lane a in the low word of each bundle
				for (int i = 0; i < bundlesPerLine; i++)
				begin
					bits[i*bundleWidth +: instrWidth] = words[2*i];
					bits[i*bundleWidth + instrWidth +: instrWidth] = words[2*i+1];
				end
				assert (code == 9 && lineCount < cacheLines) else
				begin
					errorCount++;
					$display("ERROR: line record %0d is short or one too many", lineCount);
				end
				if (lineCount < cacheLines)
				begin
					lineImage[lineCount] = bits;
					lineTarget[lineCount] = addr[shiftByteWidth-1:0];
					lineCount++;
				end
			end
			else if (tag == "A" || tag == "B")
			begin
				code = $fscanf(fd, "%d %h", regNum, value);
				assert (code == 2) else
				begin
					errorCount++;
					$display("ERROR: a lane %c writeback record is short", tag);
				end
				if (tag == "A")
					expectedA.push_back({regNum[regAddrWidth-1:0], value[dataWidth-1:0]});
				else
					expectedB.push_back({regNum[regAddrWidth-1:0], value[dataWidth-1:0]});
			end
		end
		$fclose(fd);
	endtask

	// address byte, data bytes from byte 0 up, then the write request
	task automatic loadLine(input logic [shiftByteWidth-1:0] addr,
		input logic [lineWidth-1:0] bits);
		shiftEn_i = 1'b1;
		isAddress_i = 1'b1;
		shiftOutEn_i = 1'b0;
		shiftData_i = addr;
		stepCycle();
		isAddress_i = 1'b0;
		for (int b = 0; b < lineBytes; b++)
		begin
			shiftData_i = bits[b*shiftByteWidth +: shiftByteWidth];
			stepCycle();
		end
		shiftOutEn_i = 1'b1;
		shiftData_i = '0;
		stepCycle();
		shiftOutEn_i = 1'b0;
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial
	begin
		reset_i = 1'b1;
		shiftEn_i = 1'b0;
		isAddress_i = 1'b0;
		shiftOutEn_i = 1'b0;
		shiftData_i = '0;
		readProgram();
		assert (lineCount == cacheLines) else
		begin
			errorCount++;
			$display("ERROR: program file holds %0d cache lines instead of %0d", lineCount,
				cacheLines);
		end
		// first edge clears the registers and later reset edges are checked
		@(posedge clock_i);
		#1;
		repeat (resetCycles - 1) stepCycle();
		reset_i = 1'b0;
		if (errorCount == 0)
		begin
			for (int i = 0; i < lineCount; i++)
				loadLine(lineTarget[i], lineImage[i]);
			// fetch starts at pc 0 once the loader lets go
			shiftEn_i = 1'b0;
			running = 1'b1;
			for (runCycle = 0; runCycle < pipeDepth + programBundles; runCycle++)
				stepCycle();
			assert (expectedA.size() == 0 && expectedB.size() == 0) else
			begin
				errorCount++;
				$display("ERROR: %0d lane A and %0d lane B expected writebacks never appeared",
					expectedA.size(), expectedB.size());
			end
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// cycle budget counted out of reset
	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock_i);
			if (!reset_i)
				cycleCount++;
		end
		$display("timeout: run not finished after %0d cycles out of reset", cycleLimit);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- verif/program_input.txt
# L lineAddr, then bundles 0..3 as laneA laneB instruction words (hex)
# A or B, destination register (decimal), written value (hex): expected writebacks in order
L 0 0D081234 0D10FFF0 03100020 02080002 04080002 00000000 0B0800FF FE080005
L 1 0D180F0F 0D185555 071800FF 08200003 05280001 0A200003 0C300005 02280004
L 2 06300005 09388001 00000000 00000000 02380006 00000000 00000000 04400007
L 3 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
L 4 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
L 5 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
L 6 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
L 7 00000000 00000000 00000000 00000000 00000000 00000000 0C480008 02400008
A 1 1234
B 2 FFF0
A 2 0010
B 1 1224
A 1 1214
A 1 12EB
A 3 0F0F
B 3 5555
A 3 0055
B 4 5555
A 5 FFFF
B 4 5500
A 6 FFFF
B 5 54FF
A 6 54FF
B 7 8001
A 7 D500
B 8 2B00
A 9 2B00
B 8 5600

//--- paCore.f
logic/paCorePkg.sv
logic/laneOpIf.sv
logic/issueIf.sv
logic/cacheLoadShifter.sv
logic/instructionCache.sv
logic/bundleSplitter.sv
logic/instructionDecoder.sv
logic/registerFile.sv
logic/arithmeticUnit.sv
logic/paCore.sv
verif/paCoreTb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the paCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module paCoreTb -f paCore.f -Mdir obj_dir -o paCoreSim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/paCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
